// File: hw/blas_macros.svh
/*
 * Build-time sizing of the BLAS engine
 * Grid shape, data word width, dmem depth and issue-number width
 */

`ifndef BLAS_MACROS_SVH
`define BLAS_MACROS_SVH

// Tile grid
`define BLAS_NUM_ROWS		2
`define BLAS_NUM_CLMS		2

// Word and memory sizing
`define BLAS_DATA_W			16
`define BLAS_DMEM_DEPTH		16		// Power of two, address width follows

// Issue tag, wraps around
`define BLAS_ISSUE_W		4

`endif

// File: hw/pkg_tpu.sv
/*
 * Tile-side types
 * Derived widths, opcodes, instruction word, TPU dmem access, route packet
 */

`include "blas_macros.svh"

package pkg_tpu;

	localparam int ADDR_W	= $clog2(`BLAS_DMEM_DEPTH);
	localparam int ROW_W	= (`BLAS_NUM_ROWS > 1) ? $clog2(`BLAS_NUM_ROWS) : 1;
	localparam int CLM_W	= (`BLAS_NUM_CLMS > 1) ? $clog2(`BLAS_NUM_CLMS) : 1;

	typedef logic [`BLAS_DATA_W-1:0]	data_t;
	typedef logic [ADDR_W-1:0]			addr_t;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MUL,		// Low half of the product
		OP_MAX		// Unsigned
	} op_t;

	// dst = src_a <op> src_b
	typedef struct packed {
		op_t				op;
		addr_t				dst;
		addr_t				src_a;
		addr_t				src_b;
	} instr_t;

	typedef struct packed {
		logic				rd;
		logic				wr;
		addr_t				addr;
		data_t				data;
	} ldst_t;

	typedef enum logic {
		RT_ST,
		RT_LD
	} rt_kind_t;

	typedef struct packed {
		logic				valid;
		rt_kind_t			kind;
		logic [ROW_W-1:0]	row;
		logic [CLM_W-1:0]	clm;
		addr_t				addr;
		data_t				data;
	} route_pkt_t;

endpackage

// File: hw/pkg_mpu.sv
/*
 * Host-side types
 * Tile mask, host command with its decoded payload, result and status
 */

`include "blas_macros.svh"

package pkg_mpu;

	localparam int NUM_TILES = `BLAS_NUM_ROWS * `BLAS_NUM_CLMS;

	// Instruction view is padded to the width of the memory view
	localparam int PAD_W = pkg_tpu::ADDR_W + `BLAS_DATA_W - $bits(pkg_tpu::instr_t);

	typedef logic [NUM_TILES-1:0]		tile_mask_t;	// Bit row*CLMS + clm
	typedef logic [`BLAS_ISSUE_W-1:0]	issue_no_t;

	typedef enum logic [1:0] {
		CMD_ST,
		CMD_LD,
		CMD_ISSUE
	} cmd_kind_t;

	typedef struct packed {
		pkg_tpu::addr_t		addr;
		pkg_tpu::data_t		data;
	} mem_acc_t;

	typedef struct packed {
		pkg_tpu::instr_t	instr;
		logic [PAD_W-1:0]	pad;
	} instr_cmd_t;

	// One payload word, read by command kind
	typedef union packed {
		mem_acc_t			mem;
		instr_cmd_t			ins;
	} cmd_payload_u;

	typedef struct packed {
		cmd_kind_t					kind;
		logic [pkg_tpu::ROW_W-1:0]	row;
		logic [pkg_tpu::CLM_W-1:0]	clm;
		tile_mask_t					mask;		// Issue only
		cmd_payload_u				payload;
	} mpu_in_t;

	typedef enum logic {
		OUT_LD,
		OUT_COMMIT
	} out_kind_t;

	typedef struct packed {
		logic				valid;
		out_kind_t			kind;
		issue_no_t			issue_no;
		pkg_tpu::data_t		data;
	} mpu_out_t;

	typedef struct packed {
		logic				busy;
		logic				error;
		logic [3:0]			commit_cnt;
		logic [3:0]			drop_cnt;
	} mpu_stat_t;

endpackage

// File: hw/router.sv
/*
 * Route node of the tile grid
 * Registered forward steering to dmem, down or across,
 * registered merge of the reply paths
 */

`timescale 1ns/1ns

module router #(
	parameter int ROW = 0,
	parameter int CLM = 0
) (
	input	logic					clock,
	input	logic					arst_n,
	input	pkg_tpu::route_pkt_t	fwd_in,
	output	pkg_tpu::route_pkt_t	fwd_down,
	output	pkg_tpu::route_pkt_t	fwd_across,
	output	pkg_tpu::route_pkt_t	to_mem,
	input	pkg_tpu::route_pkt_t	bwd_down,
	input	pkg_tpu::route_pkt_t	bwd_across,
	input	pkg_tpu::route_pkt_t	from_mem,
	output	pkg_tpu::route_pkt_t	bwd_out
);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			fwd_down	<= '0;
			fwd_across	<= '0;
			to_mem		<= '0;
			bwd_out		<= '0;
		end else begin
			fwd_down	<= '0;
			fwd_across	<= '0;
			to_mem		<= '0;

			// Column first along row 0, then down the column
			if (fwd_in.valid) begin
				if (fwd_in.clm != CLM)
					fwd_across <= fwd_in;
				else if (fwd_in.row != ROW)
					fwd_down <= fwd_in;
				else
					to_mem <= fwd_in;
			end

			// At most one reply is in flight
			bwd_out <= pkg_tpu::route_pkt_t'(from_mem | bwd_down | bwd_across);
		end
	end

endmodule

// File: hw/tpu.sv
/*
 * Tile execution unit
 * Operand A read, operand B read, compute with write-back, term pulse
 */

`timescale 1ns/1ns
`include "blas_macros.svh"

module tpu (
	input	logic						clock,
	input	logic						arst_n,
	input	logic						req,
	input	pkg_tpu::instr_t			instr,
	input	logic [`BLAS_ISSUE_W-1:0]	issue_no,
	output	pkg_tpu::ldst_t				ldst,
	input	pkg_tpu::data_t				ld_data,
	output	logic						term,
	output	logic [`BLAS_ISSUE_W-1:0]	term_no
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RD_A,
		S_RD_B,
		S_WB
	} state_t;

	state_t						state;
	pkg_tpu::instr_t			instr_r;
	logic [`BLAS_ISSUE_W-1:0]	ino_r;
	pkg_tpu::data_t				a_r;
	pkg_tpu::data_t				b_r;
	pkg_tpu::data_t				alu_res;

	assign term_no = ino_r;

	// Results wrap to the word width
	always_comb begin
		case (instr_r.op)
		pkg_tpu::OP_ADD:	alu_res = a_r + b_r;
		pkg_tpu::OP_SUB:	alu_res = a_r - b_r;
		pkg_tpu::OP_MUL:	alu_res = a_r * b_r;
		default:			alu_res = (a_r > b_r) ? a_r : b_r;
		endcase
	end

	always_comb begin
		ldst = '0;
		case (state)
		S_RD_A: begin
			ldst.rd		= 1'b1;
			ldst.addr	= instr_r.src_a;
		end
		S_RD_B: begin
			ldst.rd		= 1'b1;
			ldst.addr	= instr_r.src_b;
		end
		S_WB: begin
			ldst.wr		= 1'b1;
			ldst.addr	= instr_r.dst;
			ldst.data	= alu_res;
		end
		default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (state == S_IDLE && req) begin
			instr_r	<= instr;
			ino_r	<= issue_no;
		end
		if (state == S_RD_A)
			a_r <= ld_data;		// dmem read is combinational
		if (state == S_RD_B)
			b_r <= ld_data;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state	<= S_IDLE;
			term	<= 1'b0;
		end else begin
			term <= 1'b0;
			case (state)
			S_IDLE:		if (req) state <= S_RD_A;
			S_RD_A:		state <= S_RD_B;
			S_RD_B:		state <= S_WB;
			default: begin
				term	<= 1'b1;
				state	<= S_IDLE;
			end
			endcase
		end
	end

endmodule

// File: hw/dmem.sv
/*
 * Tile data memory
 * Router port for stores and loads, TPU port with priority
 */

`timescale 1ns/1ns
`include "blas_macros.svh"

module dmem (
	input	logic					clock,
	input	logic					arst_n,
	input	pkg_tpu::route_pkt_t	rt_in,
	output	pkg_tpu::route_pkt_t	rt_out,
	input	pkg_tpu::ldst_t			ldst,
	output	pkg_tpu::data_t			ld_data
);

	pkg_tpu::data_t		mem [`BLAS_DMEM_DEPTH];

	assign ld_data = mem[ldst.addr];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `BLAS_DMEM_DEPTH; i++)
				mem[i] <= '0;
			rt_out <= '0;
		end else begin
			rt_out <= '0;
			if (ldst.wr) begin
				mem[ldst.addr] <= ldst.data;
			end else if (rt_in.valid && !ldst.rd) begin
				if (rt_in.kind == pkg_tpu::RT_ST)
					mem[rt_in.addr] <= rt_in.data;
				else
					rt_out <= '{valid: 1'b1, kind: pkg_tpu::RT_LD,
						row: rt_in.row, clm: rt_in.clm,
						addr: rt_in.addr, data: mem[rt_in.addr]};
			end
		end
	end

endmodule

// File: hw/commit_agg.sv
/*
 * Commit aggregator
 * Gathers per-tile term pulses against the issue mask into one commit,
 * sticky flag for term issue numbers that do not match
 */

`timescale 1ns/1ns
`include "blas_macros.svh"

module commit_agg (
	input	logic													clock,
	input	logic													arst_n,
	input	logic													issue_req,
	input	pkg_mpu::tile_mask_t									issue_mask,
	input	logic [`BLAS_ISSUE_W-1:0]								issue_no,
	output	logic													commit_req,
	output	logic [`BLAS_ISSUE_W-1:0]								commit_no,
	input	pkg_mpu::tile_mask_t									term,
	input	logic [pkg_mpu::NUM_TILES-1:0][`BLAS_ISSUE_W-1:0]		term_no,
	output	logic													mismatch
);

	pkg_mpu::tile_mask_t		en;
	pkg_mpu::tile_mask_t		done;
	pkg_mpu::tile_mask_t		bad;
	logic						active;

	always_comb begin
		for (int i = 0; i < pkg_mpu::NUM_TILES; i++)
			bad[i] = term[i] && (term_no[i] != commit_no);
	end

	always_ff @(posedge clock) begin
		if (issue_req)
			commit_no <= issue_no;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			en			<= '0;
			done		<= '0;
			active		<= 1'b0;
			commit_req	<= 1'b0;
			mismatch	<= 1'b0;
		end else begin
			commit_req <= 1'b0;
			if (issue_req) begin
				en			<= issue_mask;
				done		<= '0;
				active		<= (issue_mask != '0);
				commit_req	<= (issue_mask == '0);		// Nothing to wait for
			end else if (active) begin
				done <= done | term;
				if ((done | term) == en) begin
					commit_req	<= 1'b1;
					active		<= 1'b0;
				end
			end
			if (|bad)
				mismatch <= 1'b1;
		end
	end

endmodule

// File: hw/mpu.sv
/*
 * MPU control unit
 * Host command decode, issue sequencing, busy level,
 * load and commit results, status counters
 */

`timescale 1ns/1ns
`include "blas_macros.svh"

module mpu (
	input	logic						clock,
	input	logic						arst_n,
	input	logic						req,
	input	pkg_mpu::mpu_in_t			cmd,
	output	pkg_mpu::mpu_out_t			result,
	output	pkg_mpu::mpu_stat_t			status,
	output	logic						wait_busy,
	output	pkg_mpu::tile_mask_t		tpu_req,
	output	pkg_tpu::instr_t			instr,
	output	logic [`BLAS_ISSUE_W-1:0]	issue_no,
	output	logic						issue_req,
	output	pkg_mpu::tile_mask_t		issue_mask,
	input	logic						commit_req,
	input	logic [`BLAS_ISSUE_W-1:0]	commit_no,
	output	pkg_tpu::route_pkt_t		st_pkt,
	input	pkg_tpu::route_pkt_t		ld_pkt
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT_CMT,
		S_WAIT_LD
	} state_t;

	state_t							state;
	pkg_mpu::tile_mask_t			mask_r;
	logic [`BLAS_ISSUE_W-1:0]		issue_cnt;
	logic [3:0]						commit_cnt;
	logic [3:0]						drop_cnt;
	logic							accept;

	assign wait_busy	= (state != S_IDLE);
	assign accept		= req && !wait_busy;
	assign issue_no		= issue_cnt;
	assign issue_mask	= mask_r;

	assign status = '{busy: wait_busy, error: 1'b0, commit_cnt: commit_cnt, drop_cnt: drop_cnt};

	// Held for the whole issue
	always_ff @(posedge clock) begin
		if (accept && cmd.kind == pkg_mpu::CMD_ISSUE) begin
			instr	<= cmd.payload.ins.instr;
			mask_r	<= cmd.mask;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state		<= S_IDLE;
			st_pkt		<= '0;
			tpu_req		<= '0;
			issue_req	<= 1'b0;
			result		<= '0;
			issue_cnt	<= '0;
			commit_cnt	<= '0;
			drop_cnt	<= '0;
		end else begin
			st_pkt.valid	<= 1'b0;
			tpu_req			<= '0;
			issue_req		<= 1'b0;
			result.valid	<= 1'b0;

			if (req && wait_busy)
				drop_cnt <= drop_cnt + 1'b1;

			case (state)
			S_IDLE: if (req) begin
				case (cmd.kind)
				pkg_mpu::CMD_ST, pkg_mpu::CMD_LD: begin
					st_pkt <= '{valid: 1'b1,
						kind: (cmd.kind == pkg_mpu::CMD_LD) ? pkg_tpu::RT_LD : pkg_tpu::RT_ST,
						row: cmd.row, clm: cmd.clm,
						addr: cmd.payload.mem.addr, data: cmd.payload.mem.data};
					if (cmd.kind == pkg_mpu::CMD_LD)
						state <= S_WAIT_LD;		// Stores are fire and forget
				end
				pkg_mpu::CMD_ISSUE: state <= S_ISSUE;
				default: drop_cnt <= drop_cnt + 1'b1;	// Unknown kind
				endcase
			end
			S_ISSUE: begin
				tpu_req		<= mask_r;
				issue_req	<= 1'b1;
				state		<= S_WAIT_CMT;
			end
			S_WAIT_CMT: if (commit_req) begin
				result <= '{valid: 1'b1, kind: pkg_mpu::OUT_COMMIT,
					issue_no: commit_no, data: '0};
				commit_cnt	<= commit_cnt + 1'b1;
				issue_cnt	<= issue_cnt + 1'b1;
				state		<= S_IDLE;
			end
			S_WAIT_LD: if (ld_pkt.valid && ld_pkt.kind == pkg_tpu::RT_LD) begin
				result <= '{valid: 1'b1, kind: pkg_mpu::OUT_LD,
					issue_no: issue_cnt, data: ld_pkt.data};
				state <= S_IDLE;
			end
			default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: hw/blas_engine.sv
/*
 * BLAS engine top
 * MPU, commit aggregator and the grid of router, TPU and dmem tiles
 */

`timescale 1ns/1ns
`include "blas_macros.svh"

module blas_engine (
	input	logic					clock,
	input	logic					arst_n,
	input	logic					req,
	input	pkg_mpu::mpu_in_t		cmd,
	output	pkg_mpu::mpu_out_t		result,
	output	pkg_mpu::mpu_stat_t		status,
	output	logic					wait_busy
);

	pkg_tpu::instr_t			issue_instr;
	logic [`BLAS_ISSUE_W-1:0]	issue_no;
	logic [`BLAS_ISSUE_W-1:0]	commit_no;
	logic						issue_req;
	logic						commit_req;
	logic						mismatch;
	pkg_mpu::tile_mask_t		tpu_req;
	pkg_mpu::tile_mask_t		issue_mask;
	pkg_mpu::tile_mask_t		term;
	pkg_mpu::mpu_stat_t			mpu_stat;

	logic [pkg_mpu::NUM_TILES-1:0][`BLAS_ISSUE_W-1:0]	term_no;

	// Route meshes with one spare row and column for the edges
	pkg_tpu::route_pkt_t	fwd_dn		[`BLAS_NUM_ROWS:0][`BLAS_NUM_CLMS-1:0];
	pkg_tpu::route_pkt_t	fwd_ac		[`BLAS_NUM_ROWS-1:0][`BLAS_NUM_CLMS:0];
	pkg_tpu::route_pkt_t	bwd_o		[`BLAS_NUM_ROWS:0][`BLAS_NUM_CLMS:0];
	pkg_tpu::route_pkt_t	bwd_ac		[`BLAS_NUM_ROWS-1:0][`BLAS_NUM_CLMS-1:0];
	pkg_tpu::route_pkt_t	to_mem		[`BLAS_NUM_ROWS-1:0][`BLAS_NUM_CLMS-1:0];
	pkg_tpu::route_pkt_t	from_mem	[`BLAS_NUM_ROWS-1:0][`BLAS_NUM_CLMS-1:0];
	pkg_tpu::ldst_t			ldst		[`BLAS_NUM_ROWS-1:0][`BLAS_NUM_CLMS-1:0];
	pkg_tpu::data_t			ld_data		[`BLAS_NUM_ROWS-1:0][`BLAS_NUM_CLMS-1:0];

	always_comb begin
		status			= mpu_stat;
		status.error	= mismatch;
	end

	mpu u_mpu (
		.clock		(clock),
		.arst_n		(arst_n),
		.req		(req),
		.cmd		(cmd),
		.result		(result),
		.status		(mpu_stat),
		.wait_busy	(wait_busy),
		.tpu_req	(tpu_req),
		.instr		(issue_instr),
		.issue_no	(issue_no),
		.issue_req	(issue_req),
		.issue_mask	(issue_mask),
		.commit_req	(commit_req),
		.commit_no	(commit_no),
		.st_pkt		(fwd_ac[0][0]),
		.ld_pkt		(bwd_o[0][0])
	);

	commit_agg u_commit_agg (
		.clock		(clock),
		.arst_n		(arst_n),
		.issue_req	(issue_req),
		.issue_mask	(issue_mask),
		.issue_no	(issue_no),
		.commit_req	(commit_req),
		.commit_no	(commit_no),
		.term		(term),
		.term_no	(term_no),
		.mismatch	(mismatch)
	);

	////////////////////////////////////////////////////////////////////////////
	// Mesh edges
	for (genvar clm = 0; clm < `BLAS_NUM_CLMS; clm++) begin : g_clm_edge
		assign fwd_dn[0][clm]				= fwd_ac[0][clm];	// Row 0 fed from across
		assign bwd_o[`BLAS_NUM_ROWS][clm]	= '0;
	end

	for (genvar row = 0; row < `BLAS_NUM_ROWS; row++) begin : g_row_edge
		assign bwd_o[row][`BLAS_NUM_CLMS] = '0;
		for (genvar clm = 0; clm < `BLAS_NUM_CLMS; clm++) begin : g_bwd_ac
			if (row == 0) begin : g_top
				assign bwd_ac[row][clm] = bwd_o[row][clm+1];
			end else begin : g_tie
				assign bwd_ac[row][clm] = '0;		// Replies only cross on row 0
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tiles
	for (genvar row = 0; row < `BLAS_NUM_ROWS; row++) begin : g_row
		for (genvar clm = 0; clm < `BLAS_NUM_CLMS; clm++) begin : g_clm
			localparam int IDX = row * `BLAS_NUM_CLMS + clm;

			router #(.ROW(row), .CLM(clm)) u_router (
				.clock		(clock),
				.arst_n		(arst_n),
				.fwd_in		(fwd_dn[row][clm]),
				.fwd_down	(fwd_dn[row+1][clm]),
				.fwd_across	(fwd_ac[row][clm+1]),
				.to_mem		(to_mem[row][clm]),
				.bwd_down	(bwd_o[row+1][clm]),
				.bwd_across	(bwd_ac[row][clm]),
				.from_mem	(from_mem[row][clm]),
				.bwd_out	(bwd_o[row][clm])
			);

			tpu u_tpu (
				.clock		(clock),
				.arst_n		(arst_n),
				.req		(tpu_req[IDX]),
				.instr		(issue_instr),
				.issue_no	(issue_no),
				.ldst		(ldst[row][clm]),
				.ld_data	(ld_data[row][clm]),
				.term		(term[IDX]),
				.term_no	(term_no[IDX])
			);

			dmem u_dmem (
				.clock		(clock),
				.arst_n		(arst_n),
				.rt_in		(to_mem[row][clm]),
				.rt_out		(from_mem[row][clm]),
				.ldst		(ldst[row][clm]),
				.ld_data	(ld_data[row][clm])
			);
		end
	end

endmodule

// File: verification/tb_blas_engine.sv
/*
 * Testbench for the BLAS engine
 * Clock and reset, host commands read from the input file, dmem reference model,
 * result and status compares, timeout and summary
 */

`timescale 1ns/1ns
`include "blas_macros.svh"

module tb_blas_engine;

	localparam int NUM_TESTS	= 38;
	localparam int NUM_COLS		= 12;
	localparam int WAIT_CYC		= 30;		// Well above the farthest load or an issue
	localparam int GAP			= 4;		// Host spacing between commands
	localparam int TIMEOUT_CYC	= NUM_TESTS * 40 + 100;

	// Test kinds in the first column
	localparam int K_ST			= 0;
	localparam int K_LD			= 1;
	localparam int K_ISSUE		= 2;
	localparam int K_DROP		= 3;		// Load with a store sent behind it while busy
	localparam int K_STAT		= 4;

	logic					clock;
	logic					arst_n;
	logic					req;
	pkg_mpu::mpu_in_t		cmd;
	pkg_mpu::mpu_out_t		result;
	pkg_mpu::mpu_stat_t		status;
	logic					wait_busy;

	logic [15:0]			stim [NUM_TESTS*NUM_COLS];
	pkg_tpu::data_t			model_mem [pkg_mpu::NUM_TILES][`BLAS_DMEM_DEPTH];
	pkg_mpu::issue_no_t		model_ino;
	logic [3:0]				model_commits;
	logic [3:0]				model_drops;
	int						n_pass;
	int						n_fail;
	int						cycles = 0;

	blas_engine u_dut (
		.clock		(clock),
		.arst_n		(arst_n),
		.req		(req),
		.cmd		(cmd),
		.result		(result),
		.status		(status),
		.wait_busy	(wait_busy)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Run stopped after %0d cycles without reaching the end", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compares and reference model
	task automatic check_out(input int test_no, input pkg_mpu::mpu_out_t got,
			input pkg_mpu::mpu_out_t exp);
		if (got !== exp) begin
			$display("[FAIL] test %0d result got %h expected %h", test_no, got, exp);
			n_fail++;
		end else begin
			$display("[PASS] test %0d result %h", test_no, got);
			n_pass++;
		end
	endtask

	task automatic check_stat(input int test_no, input pkg_mpu::mpu_stat_t got,
			input pkg_mpu::mpu_stat_t exp);
		if (got !== exp) begin
			$display("[FAIL] test %0d status got %h expected %h", test_no, got, exp);
			n_fail++;
		end else begin
			$display("[PASS] test %0d status %h", test_no, got);
			n_pass++;
		end
	endtask

	// File values must agree with the model
	function automatic void check_file(input int test_no, input logic [15:0] file_val,
			input logic [15:0] model_val);
		if (file_val !== model_val) begin
			$display("Test %0d input file expects %h but the model gives %h",
				test_no, file_val, model_val);
			n_fail++;
		end
	endfunction

	function automatic pkg_tpu::data_t apply_op(input pkg_tpu::op_t op,
			input pkg_tpu::data_t a, input pkg_tpu::data_t b);
		case (op)
		pkg_tpu::OP_ADD:	return a + b;
		pkg_tpu::OP_SUB:	return a - b;
		pkg_tpu::OP_MUL:	return a * b;		// Low half only
		default:			return (a > b) ? a : b;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Host side driving
	task automatic send_cmd(input pkg_mpu::mpu_in_t c);
		@(negedge clock);
		req = 1'b1;
		cmd = c;
		@(negedge clock);
		req = 1'b0;
	endtask

	task automatic send_with_drop(input pkg_mpu::mpu_in_t c, input pkg_mpu::mpu_in_t extra);
		@(negedge clock);
		req = 1'b1;
		cmd = c;
		@(negedge clock);
		if (wait_busy !== 1'b1) begin
			$display("Engine was not busy when the extra command went out");
			n_fail++;
		end
		cmd = extra;
		@(negedge clock);
		req = 1'b0;
	endtask

	task automatic wait_result(input int test_no, output pkg_mpu::mpu_out_t got,
			output bit seen);
		seen = 1'b0;
		got = '0;
		for (int n = 0; n < WAIT_CYC && !seen; n++) begin
			@(negedge clock);
			if (result.valid) begin
				seen = 1'b1;
				got = result;
			end
		end
		if (!seen) begin
			$display("Test %0d got no result pulse within %0d cycles", test_no, WAIT_CYC);
			n_fail++;
		end
	endtask

	initial begin
		pkg_mpu::mpu_in_t		c;
		pkg_mpu::mpu_in_t		c_extra;
		pkg_mpu::mpu_out_t		got;
		pkg_mpu::mpu_out_t		exp_out;
		pkg_mpu::mpu_stat_t		exp_stat;
		pkg_tpu::data_t			st_data;
		logic [15:0]			f [NUM_COLS];	// One input line, columns as in the file
		logic [31:0]			rword;
		bit						seen;
		int						tile;

		arst_n = 1'b0;
		req = 1'b0;
		cmd = '0;
		n_pass = 0;
		n_fail = 0;
		model_ino = '0;
		model_commits = '0;
		model_drops = '0;
		for (int i = 0; i < pkg_mpu::NUM_TILES; i++)
			for (int a = 0; a < `BLAS_DMEM_DEPTH; a++)
				model_mem[i][a] = '0;
		void'($urandom(32'hdcc6));
		$readmemh("verification/blas_engine_input.txt", stim);

		repeat (5) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int i = 0; i < NUM_COLS; i++)
				f[i] = stim[t*NUM_COLS + i];
			tile = f[1] * `BLAS_NUM_CLMS + f[2];
			c = '0;
			c.row = f[1][pkg_tpu::ROW_W-1:0];
			c.clm = f[2][pkg_tpu::CLM_W-1:0];
			c.mask = f[3][pkg_mpu::NUM_TILES-1:0];

			case (f[0])
			K_ST: begin
				st_data = f[8];
				if (f[9][0]) begin
					rword = $urandom;
					st_data = rword[15:0];		// Spare word, tracked by the model
				end
				c.kind = pkg_mpu::CMD_ST;
				c.payload.mem.addr = f[5][pkg_tpu::ADDR_W-1:0];
				c.payload.mem.data = st_data;
				send_cmd(c);
				model_mem[tile][f[5]] = st_data;
				repeat (GAP) @(negedge clock);
				exp_stat = '{busy: 1'b0, error: 1'b0,
					commit_cnt: model_commits, drop_cnt: model_drops};
				check_stat(t, status, exp_stat);
			end
			K_LD, K_DROP: begin
				c.kind = pkg_mpu::CMD_LD;
				c.payload.mem.addr = f[5][pkg_tpu::ADDR_W-1:0];
				if (f[0] == K_DROP) begin
					c_extra = c;
					c_extra.kind = pkg_mpu::CMD_ST;
					c_extra.payload.mem.data = f[8];
					send_with_drop(c, c_extra);
					model_drops++;
				end else begin
					send_cmd(c);
				end
				wait_result(t, got, seen);
				if (!f[9][0])
					check_file(t, f[10], model_mem[tile][f[5]]);
				check_file(t, f[11], model_ino);
				exp_out = '{valid: 1'b1, kind: pkg_mpu::OUT_LD,
					issue_no: model_ino, data: model_mem[tile][f[5]]};
				if (seen)
					check_out(t, got, exp_out);
				repeat (GAP) @(negedge clock);
			end
			K_ISSUE: begin
				c.kind = pkg_mpu::CMD_ISSUE;
				c.payload.ins.instr = '{op: pkg_tpu::op_t'(f[4][1:0]),
					dst: f[5][pkg_tpu::ADDR_W-1:0],
					src_a: f[6][pkg_tpu::ADDR_W-1:0],
					src_b: f[7][pkg_tpu::ADDR_W-1:0]};
				send_cmd(c);
				wait_result(t, got, seen);
				check_file(t, f[11], model_ino);
				exp_out = '{valid: 1'b1, kind: pkg_mpu::OUT_COMMIT,
					issue_no: model_ino, data: '0};
				if (seen)
					check_out(t, got, exp_out);
				for (int i = 0; i < pkg_mpu::NUM_TILES; i++)
					if (f[3][i])
						model_mem[i][f[5]] = apply_op(pkg_tpu::op_t'(f[4][1:0]),
							model_mem[i][f[6]], model_mem[i][f[7]]);
				model_ino++;
				model_commits++;
				repeat (GAP) @(negedge clock);
			end
			K_STAT: begin
				exp_stat = '{busy: 1'b0, error: 1'b0,
					commit_cnt: model_commits, drop_cnt: model_drops};
				check_file(t, f[10], exp_stat);
				check_stat(t, status, exp_stat);
			end
			default: begin
				$display("Test %0d has an unknown kind %h in the input file", t, f[0]);
				n_fail++;
			end
			endcase
		end

		$display("Checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verification/blas_engine_input.txt
// kind(0 st,1 ld,2 issue,3 ld with dropped st,4 status) row clm mask op addr/dst
// src_a src_b data random_data exp_data(load word or status word) exp_issue_no
4 0 0 0 0 0 0 0 0000 0 0000 0
1 0 0 0 0 0 0 0 0000 0 0000 0
1 0 1 0 0 5 0 0 0000 0 0000 0
1 1 0 0 0 a 0 0 0000 0 0000 0
1 1 1 0 0 f 0 0 0000 0 0000 0
0 0 0 0 0 1 0 0 1234 0 0000 0
1 0 0 0 0 1 0 0 0000 0 1234 0
0 0 1 0 0 1 0 0 8000 0 0000 0
1 0 1 0 0 1 0 0 0000 0 8000 0
0 1 0 0 0 1 0 0 0003 0 0000 0
1 1 0 0 0 1 0 0 0000 0 0003 0
0 1 1 0 0 1 0 0 00ff 0 0000 0
1 1 1 0 0 1 0 0 0000 0 00ff 0
0 0 0 0 0 2 0 0 0f0f 0 0000 0
0 0 1 0 0 2 0 0 9001 0 0000 0
0 1 0 0 0 2 0 0 ffff 0 0000 0
0 1 1 0 0 2 0 0 0101 0 0000 0
2 0 0 f 0 3 1 2 0000 0 0000 0
2 0 0 f 1 4 1 2 0000 0 0000 1
2 0 0 f 2 5 1 2 0000 0 0000 2
2 0 0 f 3 6 1 2 0000 0 0000 3
1 0 0 0 0 3 0 0 0000 0 2143 4
1 0 1 0 0 4 0 0 0000 0 efff 4
1 1 0 0 0 5 0 0 0000 0 fffd 4
1 1 1 0 0 6 0 0 0000 0 0101 4
1 0 0 0 0 5 0 0 0000 0 1d0c 4
2 0 0 5 1 3 1 2 0000 0 0000 4
1 0 0 0 0 3 0 0 0000 0 0325 5
1 1 0 0 0 3 0 0 0000 0 0004 5
1 0 1 0 0 3 0 0 0000 0 1001 5
1 1 1 0 0 3 0 0 0000 0 0200 5
2 0 0 0 0 0 1 2 0000 0 0000 5
0 1 1 0 0 8 0 0 0000 1 0000 6
2 0 0 8 0 a 8 8 0000 0 0000 6
1 1 1 0 0 a 0 0 0000 1 0000 7
3 1 0 0 0 5 0 0 5555 0 fffd 7
1 1 0 0 0 5 0 0 0000 0 fffd 7
4 0 0 0 0 0 0 0 0000 0 0071 0

// File: flist.f
+incdir+hw
hw/pkg_tpu.sv
hw/pkg_mpu.sv
hw/router.sv
hw/tpu.sv
hw/dmem.sv
hw/commit_agg.sv
hw/mpu.sv
hw/blas_engine.sv
verification/tb_blas_engine.sv
